/* compile.f */
+incdir+include
verilog/nocchk_pkg.sv
verilog/flit_if.sv
verilog/route_decoder.sv
verilog/error_responder.sv
verilog/flit_merger.sv
verilog/error_checker_top.sv
dv/tb_error_checker.sv

/* Makefile */
# Verilator build and run for the packet error checker

VERILATOR  ?= verilator
TOP        ?= tb_error_checker
FILELIST   ?= compile.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing
PASS_MSG   ?= Result: PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# The run passes only when the pass message shows up in the output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* dv/tb_error_checker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "nocchk_defines.svh"

module tb_error_checker import nocchk_pkg::*; ();

  localparam int WAIT_LIMIT  = 200;
  localparam int DRAIN_LIMIT = 4000;
  localparam ptype_t TYPE_LIST [5] = '{PTYPE_POSTED_WRITE, PTYPE_NP_WRITE, PTYPE_READ,
                                       PTYPE_RESPONSE, PTYPE_RESPONSE_DATA};

  logic        clk;
  logic        rst_n;
  logic        flit_in_valid;
  logic        flit_in_ready;
  logic        flit_in_head;
  logic        flit_in_tail;
  flit_data_t  flit_in_data;
  logic        flit_out_valid;
  logic        flit_out_ready;
  logic        flit_out_head;
  logic        flit_out_tail;
  flit_data_t  flit_out_data;

  integer      seed = 32'hea77_9426;
  int          errors = 0;
  int          flits_seen = 0;
  logic        stalls_on = 1'b0;
  logic        gaps_on = 1'b0;
  logic        in_resp = 1'b0;
  logic        have_exp;
  logic [33:0] exp_flit;
  // Each entry is {head, tail, data}
  logic [33:0] norm_q[$];
  logic [33:0] resp_q[$];

  error_checker_top u_dut (
    .clk            (clk),
    .rst_n          (rst_n),
    .flit_in_valid  (flit_in_valid),
    .flit_in_ready  (flit_in_ready),
    .flit_in_head   (flit_in_head),
    .flit_in_tail   (flit_in_tail),
    .flit_in_data   (flit_in_data),
    .flit_out_valid (flit_out_valid),
    .flit_out_ready (flit_out_ready),
    .flit_out_head  (flit_out_head),
    .flit_out_tail  (flit_out_tail),
    .flit_out_data  (flit_out_data)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Stall draws happen on the edge itself, the main thread draws 2 ns later
  initial begin
    logic stall;
    flit_out_ready = 1'b1;
    forever begin
      @(posedge clk);
      stall = (($random(seed) & 3) == 0);
      #2;
      flit_out_ready = !(stalls_on && stall);
    end
  end

  // ************************************************************
  // Reference model
  // ************************************************************
  function automatic flit_data_t make_head(input ptype_t ptype, input coord_t dst_x,
                                           input coord_t dst_y, input coord_t src_x,
                                           input coord_t src_y, input tag_t tag,
                                           input burst_len_t len);
    flit_data_t hdr;
    hdr = '0;
    hdr[`NOCCHK_TYPE_MSB:`NOCCHK_TYPE_LSB]   = ptype;
    hdr[`NOCCHK_DST_X_MSB:`NOCCHK_DST_X_LSB] = dst_x;
    hdr[`NOCCHK_DST_Y_MSB:`NOCCHK_DST_Y_LSB] = dst_y;
    hdr[`NOCCHK_SRC_X_MSB:`NOCCHK_SRC_X_LSB] = src_x;
    hdr[`NOCCHK_SRC_Y_MSB:`NOCCHK_SRC_Y_LSB] = src_y;
    hdr[`NOCCHK_TAG_MSB:`NOCCHK_TAG_LSB]     = tag;
    hdr[`NOCCHK_LEN_MSB:`NOCCHK_LEN_LSB]     = len;
    return hdr;
  endfunction

  // Number of flits sent back for a request with a bad destination
  function automatic int response_flits(input flit_data_t req);
    ptype_t ptype;
    ptype = req[`NOCCHK_TYPE_MSB:`NOCCHK_TYPE_LSB];
    if (ptype == PTYPE_NP_WRITE) return 1;
    if (ptype == PTYPE_READ) return 1 + int'(req[`NOCCHK_LEN_MSB:`NOCCHK_LEN_LSB]);
    return 0;
  endfunction

  function automatic logic [33:0] expected_response(input flit_data_t req, input int idx);
    burst_len_t n_data;
    flit_data_t hdr;
    n_data = (req[`NOCCHK_TYPE_MSB:`NOCCHK_TYPE_LSB] == PTYPE_READ) ?
             req[`NOCCHK_LEN_MSB:`NOCCHK_LEN_LSB] : '0;
    if (idx > 0) begin
      return {1'b0, idx == int'(n_data), flit_data_t'(`NOCCHK_ERROR_DATA)};
    end
    // Answer travels back to the requester, so source and destination swap
    hdr = make_head((n_data == '0) ? PTYPE_RESPONSE : PTYPE_RESPONSE_DATA,
                    req[`NOCCHK_SRC_X_MSB:`NOCCHK_SRC_X_LSB],
                    req[`NOCCHK_SRC_Y_MSB:`NOCCHK_SRC_Y_LSB],
                    req[`NOCCHK_DST_X_MSB:`NOCCHK_DST_X_LSB],
                    req[`NOCCHK_DST_Y_MSB:`NOCCHK_DST_Y_LSB],
                    req[`NOCCHK_TAG_MSB:`NOCCHK_TAG_LSB], n_data);
    hdr[`NOCCHK_STATUS_BIT] = 1'b1;
    return {1'b1, n_data == '0, hdr};
  endfunction

  // ************************************************************
  // Stimulus
  // ************************************************************
  task automatic end_run();
    $display("Run complete with %0d errors over %0d output flits", errors, flits_seen);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  endtask

  // Called 2 ns after a rising edge and returns at the same offset
  task automatic send_flit(input logic head, input logic tail, input flit_data_t data);
    int waited;
    waited = 0;
    flit_in_valid = 1'b1;
    flit_in_head  = head;
    flit_in_tail  = tail;
    flit_in_data  = data;
    @(negedge clk);
    while (!flit_in_ready && waited < WAIT_LIMIT) begin
      waited++;
      @(negedge clk);
    end
    if (!flit_in_ready) begin
      errors++;
      $display("Timeout at %0t: flit_in_ready stayed low for %0d cycles", $time, WAIT_LIMIT);
      end_run();
    end else begin
      @(posedge clk);
      #2;
      flit_in_valid = 1'b0;
    end
  endtask

  task automatic send_packet(input flit_data_t hdr);
    int         i;
    int         n_flits;
    logic       bad_dest;
    flit_data_t payload;
    n_flits = (hdr[`NOCCHK_TYPE_MSB:`NOCCHK_TYPE_LSB] == PTYPE_READ) ? 1 :
              int'(hdr[`NOCCHK_LEN_MSB:`NOCCHK_LEN_LSB]) + 1;
    bad_dest = (int'(hdr[`NOCCHK_DST_X_MSB:`NOCCHK_DST_X_LSB]) >= `NOCCHK_SIZE_X) ||
               (int'(hdr[`NOCCHK_DST_Y_MSB:`NOCCHK_DST_Y_LSB]) >= `NOCCHK_SIZE_Y);
    if (bad_dest) begin
      for (i = 0; i < response_flits(hdr); i++) begin
        resp_q.push_back(expected_response(hdr, i));
      end
    end
    for (i = 0; i < n_flits; i++) begin
      payload = (i == 0) ? hdr : flit_data_t'($random(seed));
      if (!bad_dest) begin
        norm_q.push_back({i == 0, i == n_flits - 1, payload});
      end
      send_flit(i == 0, i == n_flits - 1, payload);
      if (gaps_on) begin
        repeat ($unsigned($random(seed)) % 3) begin
          @(posedge clk);
          #2;
        end
      end
    end
  endtask

  task automatic compare_flit(input logic [33:0] exp);
    assert (flit_out_head == exp[33]) else begin
      errors++;
      $display("error %0t flit_out_head expected %b actual %b", $time, exp[33], flit_out_head);
    end
    assert (flit_out_tail == exp[32]) else begin
      errors++;
      $display("error %0t flit_out_tail expected %b actual %b", $time, exp[32], flit_out_tail);
    end
    assert (flit_out_data == exp[31:0]) else begin
      errors++;
      $display("error %0t flit_out_data expected %h actual %h", $time, exp[31:0],
               flit_out_data);
    end
  endtask

  // Outputs settle by the falling edge and hold until the next rising edge
  always @(negedge clk) begin
    if (rst_n && flit_out_valid && flit_out_ready) begin
      flits_seen++;
      if (flit_out_head) begin
        in_resp = flit_out_data[`NOCCHK_STATUS_BIT];
      end
      if (in_resp) begin
        have_exp = (resp_q.size() > 0);
        if (have_exp) exp_flit = resp_q.pop_front();
      end else begin
        have_exp = (norm_q.size() > 0);
        if (have_exp) exp_flit = norm_q.pop_front();
      end
      assert (have_exp) else begin
        errors++;
        $display("Unexpected %s flit on flit_out at %0t with nothing left to match",
                 in_resp ? "response" : "normal", $time);
      end
      if (have_exp) compare_flit(exp_flit);
    end
  end

  initial begin
    int t;
    int len;
    int k;
    int waited;
    rst_n         = 1'b0;
    flit_in_valid = 1'b0;
    flit_in_head  = 1'b0;
    flit_in_tail  = 1'b0;
    flit_in_data  = '0;
    repeat (2) @(posedge clk);
    #2;
    rst_n = 1'b1;
    assert (flit_out_valid == 1'b0) else begin
      errors++;
      $display("error %0t flit_out_valid expected 0 actual %b", $time, flit_out_valid);
    end

    // Every type and burst length with a reachable destination
    for (t = 0; t < 5; t++) begin
      for (len = 0; len <= 4; len++) begin
        send_packet(make_head(TYPE_LIST[t], coord_t'(len % 3), coord_t'(t % 3), 2'd2, 2'd1,
                              tag_t'(t * 8 + len), burst_len_t'(len)));
      end
    end

    // Posted write off the mesh is dropped, later traffic still flows
    send_packet(make_head(PTYPE_POSTED_WRITE, 2'd3, 2'd0, 2'd1, 2'd1, 8'h21, 8'd2));
    send_packet(make_head(PTYPE_NP_WRITE, 2'd1, 2'd2, 2'd0, 2'd0, 8'h22, 8'd1));
    send_packet(make_head(PTYPE_READ, 2'd0, 2'd1, 2'd2, 2'd2, 8'h23, 8'd4));

    send_packet(make_head(PTYPE_NP_WRITE, 2'd1, 2'd3, 2'd2, 2'd0, 8'h31, 8'd3));
    send_packet(make_head(PTYPE_READ, 2'd3, 2'd1, 2'd0, 2'd2, 8'h41, 8'd3));
    send_packet(make_head(PTYPE_READ, 2'd0, 2'd3, 2'd1, 2'd0, 8'h42, 8'd0));

    // ************************************************************
    // Random mix under back-pressure
    // ************************************************************
    stalls_on = 1'b1;
    gaps_on   = 1'b1;
    for (k = 0; k < 80; k++) begin
      send_packet(make_head(TYPE_LIST[$unsigned($random(seed)) % 5],
                            coord_t'($random(seed)), coord_t'($random(seed)),
                            coord_t'($random(seed)), coord_t'($random(seed)),
                            tag_t'($random(seed)),
                            burst_len_t'($unsigned($random(seed)) % 5)));
    end

    waited = 0;
    while ((norm_q.size() + resp_q.size()) > 0 && waited < DRAIN_LIMIT) begin
      @(posedge clk);
      waited++;
    end
    assert (norm_q.size() == 0) else begin
      errors++;
      $display("Normal queue still holds %0d flits after the drain timeout", norm_q.size());
    end
    assert (resp_q.size() == 0) else begin
      errors++;
      $display("Response queue still holds %0d flits after the drain timeout", resp_q.size());
    end
    // Quiet period to catch stray flits
    repeat (20) @(posedge clk);
    end_run();
  end

endmodule

`default_nettype wire

/* verilog/error_checker_top.sv */
`timescale 1ns/1ps
`default_nettype none

module error_checker_top import nocchk_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       flit_in_valid,
  output logic       flit_in_ready,
  input  logic       flit_in_head,
  input  logic       flit_in_tail,
  input  flit_data_t flit_in_data,
  output logic       flit_out_valid,
  input  logic       flit_out_ready,
  output logic       flit_out_head,
  output logic       flit_out_tail,
  output flit_data_t flit_out_data
);

  logic resp_busy;

  flit_if in_if ();
  flit_if norm_if ();
  flit_if err_if ();
  flit_if resp_if ();

  assign in_if.valid   = flit_in_valid;
  assign in_if.head    = flit_in_head;
  assign in_if.tail    = flit_in_tail;
  assign in_if.data    = flit_in_data;
  assign flit_in_ready = in_if.ready;

  route_decoder u_route_decoder (
    .clk     (clk),
    .rst_n   (rst_n),
    .in_if   (in_if),
    .norm_if (norm_if),
    .err_if  (err_if),
    .busy    (resp_busy)
  );

  error_responder u_error_responder (
    .clk     (clk),
    .rst_n   (rst_n),
    .req_if  (err_if),
    .resp_if (resp_if),
    .busy    (resp_busy)
  );

  flit_merger u_flit_merger (
    .clk            (clk),
    .rst_n          (rst_n),
    .norm_if        (norm_if),
    .resp_if        (resp_if),
    .flit_out_valid (flit_out_valid),
    .flit_out_ready (flit_out_ready),
    .flit_out_head  (flit_out_head),
    .flit_out_tail  (flit_out_tail),
    .flit_out_data  (flit_out_data)
  );

endmodule

`default_nettype wire

/* verilog/flit_merger.sv */
`timescale 1ns/1ps
`default_nettype none

module flit_merger import nocchk_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  flit_if.receiver   norm_if,
  flit_if.receiver   resp_if,
  output logic       flit_out_valid,
  input  logic       flit_out_ready,
  output logic       flit_out_head,
  output logic       flit_out_tail,
  output flit_data_t flit_out_data
);

  logic       locked;
  logic       grant_resp;
  logic       sel_resp;
  logic       sel_valid;
  logic       sel_head;
  logic       sel_tail;
  flit_data_t sel_data;
  logic       slice_ready;
  logic       in_xfer;
  logic       out_free;
  logic       skid_valid;
  logic       skid_head;
  logic       skid_tail;
  flit_data_t skid_data;

  // ************************************************************
  // Packet-locked arbiter
  // ************************************************************
  // Responses win when the arbiter is free
  assign sel_resp  = locked ? grant_resp : resp_if.valid;
  assign sel_valid = sel_resp ? resp_if.valid : norm_if.valid;
  assign sel_head  = sel_resp ? resp_if.head  : norm_if.head;
  assign sel_tail  = sel_resp ? resp_if.tail  : norm_if.tail;
  assign sel_data  = sel_resp ? resp_if.data  : norm_if.data;

  assign norm_if.ready = !sel_resp && slice_ready;
  assign resp_if.ready = sel_resp && slice_ready;
  assign in_xfer       = sel_valid && slice_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      locked     <= 1'b0;
      grant_resp <= 1'b0;
    end else if (in_xfer) begin
      if (sel_tail) begin
        locked <= 1'b0;
      end else if (sel_head) begin
        locked     <= 1'b1;
        grant_resp <= sel_resp;
      end
    end
  end

  a_grant_held: assert property (
    @(posedge clk) disable iff (!rst_n)
    (locked && !(in_xfer && sel_tail)) |=> (locked && (grant_resp == $past(grant_resp)))
  );

  // ************************************************************
  // Two-entry output slice
  // ************************************************************
  assign slice_ready = !skid_valid;
  assign out_free    = !flit_out_valid || flit_out_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      flit_out_valid <= 1'b0;
      skid_valid     <= 1'b0;
    end else if (out_free) begin
      flit_out_valid <= skid_valid || in_xfer;
      skid_valid     <= 1'b0;
    end else if (in_xfer) begin
      skid_valid <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (out_free) begin
      flit_out_head <= skid_valid ? skid_head : sel_head;
      flit_out_tail <= skid_valid ? skid_tail : sel_tail;
      flit_out_data <= skid_valid ? skid_data : sel_data;
    end else if (in_xfer) begin
      skid_head <= sel_head;
      skid_tail <= sel_tail;
      skid_data <= sel_data;
    end
  end

endmodule

`default_nettype wire

/* verilog/error_responder.sv */
`timescale 1ns/1ps
`default_nettype none

`include "nocchk_defines.svh"

module error_responder import nocchk_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  flit_if.receiver req_if,
  flit_if.sender   resp_if,
  output logic     busy
);

  resp_state_t state;
  ptype_t      req_type;
  ptype_t      cur_type;
  coord_t      req_src_x;
  coord_t      req_src_y;
  coord_t      req_dst_x;
  coord_t      req_dst_y;
  tag_t        req_tag;
  burst_len_t  resp_cnt;
  logic        req_xfer;
  logic        resp_xfer;
  logic        needs_resp;
  flit_data_t  resp_head_data;

  // ************************************************************
  // Request side
  // ************************************************************
  assign req_if.ready = (state == RESP_IDLE) || (state == RESP_DRAIN);
  assign req_xfer     = req_if.valid && req_if.ready;
  assign resp_xfer    = resp_if.valid && resp_if.ready;
  assign busy         = (state != RESP_IDLE);

  // A single-flit request is decided from the live flit, not the latched copy
  assign cur_type = (state == RESP_IDLE) ?
                    req_if.data[`NOCCHK_TYPE_MSB:`NOCCHK_TYPE_LSB] : req_type;

  // Posted writes and stray responses get no answer
  assign needs_resp = (cur_type == PTYPE_NP_WRITE) || (cur_type == PTYPE_READ);

  always_ff @(posedge clk) begin
    if ((state == RESP_IDLE) && req_xfer) begin
      req_type  <= req_if.data[`NOCCHK_TYPE_MSB:`NOCCHK_TYPE_LSB];
      req_dst_x <= req_if.data[`NOCCHK_DST_X_MSB:`NOCCHK_DST_X_LSB];
      req_dst_y <= req_if.data[`NOCCHK_DST_Y_MSB:`NOCCHK_DST_Y_LSB];
      req_src_x <= req_if.data[`NOCCHK_SRC_X_MSB:`NOCCHK_SRC_X_LSB];
      req_src_y <= req_if.data[`NOCCHK_SRC_Y_MSB:`NOCCHK_SRC_Y_LSB];
      req_tag   <= req_if.data[`NOCCHK_TAG_MSB:`NOCCHK_TAG_LSB];
    end
  end

  // ************************************************************
  // Response FSM
  // ************************************************************
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= RESP_IDLE;
    end else begin
      case (state)
        RESP_IDLE, RESP_DRAIN: begin
          if (req_xfer) begin
            if (!req_if.tail) begin
              state <= RESP_DRAIN;
            end else begin
              state <= needs_resp ? RESP_HEAD : RESP_IDLE;
            end
          end
        end
        RESP_HEAD: begin
          if (resp_xfer) begin
            state <= (resp_cnt == '0) ? RESP_IDLE : RESP_DATA;
          end
        end
        RESP_DATA: begin
          if (resp_xfer && (resp_cnt == burst_len_t'(1))) begin
            state <= RESP_IDLE;
          end
        end
        default: state <= RESP_IDLE;
      endcase
    end
  end

  // Only reads ask for data, everything else answers with a bare head
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      resp_cnt <= '0;
    end else if ((state == RESP_IDLE) && req_xfer) begin
      if (req_if.data[`NOCCHK_TYPE_MSB:`NOCCHK_TYPE_LSB] == PTYPE_READ) begin
        resp_cnt <= req_if.data[`NOCCHK_LEN_MSB:`NOCCHK_LEN_LSB];
      end else begin
        resp_cnt <= '0;
      end
    end else if ((state == RESP_DATA) && resp_xfer) begin
      resp_cnt <= resp_cnt - burst_len_t'(1);
    end
  end

  // Source and destination swap so the answer goes back to the sender
  always_comb begin
    resp_head_data = '0;
    resp_head_data[`NOCCHK_TYPE_MSB:`NOCCHK_TYPE_LSB] =
      (resp_cnt != '0) ? PTYPE_RESPONSE_DATA : PTYPE_RESPONSE;
    resp_head_data[`NOCCHK_DST_X_MSB:`NOCCHK_DST_X_LSB] = req_src_x;
    resp_head_data[`NOCCHK_DST_Y_MSB:`NOCCHK_DST_Y_LSB] = req_src_y;
    resp_head_data[`NOCCHK_SRC_X_MSB:`NOCCHK_SRC_X_LSB] = req_dst_x;
    resp_head_data[`NOCCHK_SRC_Y_MSB:`NOCCHK_SRC_Y_LSB] = req_dst_y;
    resp_head_data[`NOCCHK_TAG_MSB:`NOCCHK_TAG_LSB]     = req_tag;
    resp_head_data[`NOCCHK_LEN_MSB:`NOCCHK_LEN_LSB]     = resp_cnt;
    resp_head_data[`NOCCHK_STATUS_BIT]                  = 1'b1;
  end

  assign resp_if.valid = (state == RESP_HEAD) || (state == RESP_DATA);
  assign resp_if.head  = (state == RESP_HEAD);
  assign resp_if.tail  = (state == RESP_HEAD) ? (resp_cnt == '0) :
                                                (resp_cnt == burst_len_t'(1));
  assign resp_if.data  = (state == RESP_HEAD) ? resp_head_data : `NOCCHK_ERROR_DATA;

  a_no_resp_in_drain: assert property (
    @(posedge clk) disable iff (!rst_n)
    (state == RESP_DRAIN) |-> !resp_if.valid
  );

endmodule

`default_nettype wire

/* verilog/route_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

`include "nocchk_defines.svh"

module route_decoder import nocchk_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  flit_if.receiver in_if,
  flit_if.sender   norm_if,
  flit_if.sender   err_if,
  input  logic     busy
);

  route_state_t state;
  route_state_t route;
  coord_t       dst_x;
  coord_t       dst_y;
  logic         invalid_dest;
  logic         stall;
  logic         in_xfer;

  // ************************************************************
  // Destination check on the head flit
  // ************************************************************
  assign dst_x = in_if.data[`NOCCHK_DST_X_MSB:`NOCCHK_DST_X_LSB];
  assign dst_y = in_if.data[`NOCCHK_DST_Y_MSB:`NOCCHK_DST_Y_LSB];

  assign invalid_dest = (int'(dst_x) >= `NOCCHK_SIZE_X) ||
                        (int'(dst_y) >= `NOCCHK_SIZE_Y);

  // In IDLE the current flit is a head and decides the route,
  // afterwards the latched route holds until the tail
  always_comb begin
    if (state == ROUTE_IDLE) begin
      route = invalid_dest ? ROUTE_ERROR : ROUTE_NORMAL;
    end else begin
      route = state;
    end
  end

  // Only one error packet may be in flight, so new heads wait for the responder
  assign stall = (state == ROUTE_IDLE) && busy;

  // ************************************************************
  // Steering
  // ************************************************************
  assign norm_if.valid = in_if.valid && !stall && (route == ROUTE_NORMAL);
  assign norm_if.head  = in_if.head;
  assign norm_if.tail  = in_if.tail;
  assign norm_if.data  = in_if.data;

  assign err_if.valid = in_if.valid && !stall && (route == ROUTE_ERROR);
  assign err_if.head  = in_if.head;
  assign err_if.tail  = in_if.tail;
  assign err_if.data  = in_if.data;

  always_comb begin
    if (stall) begin
      in_if.ready = 1'b0;
    end else if (route == ROUTE_ERROR) begin
      in_if.ready = err_if.ready;
    end else begin
      in_if.ready = norm_if.ready;
    end
  end

  assign in_xfer = in_if.valid && in_if.ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= ROUTE_IDLE;
    end else if (in_xfer) begin
      if (in_if.tail) begin
        state <= ROUTE_IDLE;
      end else if (state == ROUTE_IDLE) begin
        state <= route;
      end
    end
  end

  // Heads only start a packet from IDLE
  a_head_in_idle: assert property (
    @(posedge clk) disable iff (!rst_n)
    (in_xfer && in_if.head) |-> (state == ROUTE_IDLE)
  );

  // The responder's busy flag keeps the next packet out
  a_head_not_busy: assert property (
    @(posedge clk) disable iff (!rst_n)
    (in_xfer && in_if.head) |-> !busy
  );

endmodule

`default_nettype wire

/* verilog/flit_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface flit_if import nocchk_pkg::*; ();

  logic       valid;
  logic       ready;
  logic       head;
  logic       tail;
  flit_data_t data;

  // The sender holds valid and the flit until ready is seen
  modport sender (
    output valid, head, tail, data,
    input  ready
  );

  modport receiver (
    input  valid, head, tail, data,
    output ready
  );

endinterface

`default_nettype wire

/* verilog/nocchk_pkg.sv */
`default_nettype none

`include "nocchk_defines.svh"

package nocchk_pkg;

  // ************************************************************
  // Flit field types
  // ************************************************************
  typedef logic [`NOCCHK_DATA_W-1:0]  flit_data_t;
  typedef logic [`NOCCHK_COORD_W-1:0] coord_t;
  typedef logic [`NOCCHK_TAG_W-1:0]   tag_t;
  typedef logic [`NOCCHK_LEN_W-1:0]   burst_len_t;
  typedef logic [`NOCCHK_TYPE_W-1:0]  ptype_t;

  // Packet type codes carried in the head flit
  localparam ptype_t PTYPE_POSTED_WRITE = 3'd0;
  localparam ptype_t PTYPE_NP_WRITE     = 3'd1;
  localparam ptype_t PTYPE_READ         = 3'd2;
  localparam ptype_t PTYPE_RESPONSE     = 3'd4;
  localparam ptype_t PTYPE_RESPONSE_DATA = 3'd5;

  // ************************************************************
  // State machines
  // ************************************************************
  typedef enum logic [1:0] {
    ROUTE_IDLE,
    ROUTE_NORMAL,
    ROUTE_ERROR
  } route_state_t;

  typedef enum logic [1:0] {
    RESP_IDLE,
    RESP_DRAIN,
    RESP_HEAD,
    RESP_DATA
  } resp_state_t;

endpackage

`default_nettype wire

/* include/nocchk_defines.svh */
`ifndef NOCCHK_DEFINES_SVH
`define NOCCHK_DEFINES_SVH

// Mesh dimensions
`define NOCCHK_SIZE_X 3
`define NOCCHK_SIZE_Y 3

// Field widths
`define NOCCHK_DATA_W  32
`define NOCCHK_COORD_W 2
`define NOCCHK_TAG_W   8
`define NOCCHK_LEN_W   8
`define NOCCHK_TYPE_W  3

// Head flit layout
`define NOCCHK_TYPE_MSB  31
`define NOCCHK_TYPE_LSB  29
`define NOCCHK_DST_X_MSB 28
`define NOCCHK_DST_X_LSB 27
`define NOCCHK_DST_Y_MSB 26
`define NOCCHK_DST_Y_LSB 25
`define NOCCHK_SRC_X_MSB 24
`define NOCCHK_SRC_X_LSB 23
`define NOCCHK_SRC_Y_MSB 22
`define NOCCHK_SRC_Y_LSB 21
`define NOCCHK_TAG_MSB   20
`define NOCCHK_TAG_LSB   13
`define NOCCHK_LEN_MSB   12
`define NOCCHK_LEN_LSB   5
`define NOCCHK_STATUS_BIT 4

// Payload of every error response data flit
`define NOCCHK_ERROR_DATA 32'hbad0_da7a

`endif
